// File: hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // only OKAY is ever returned by the slaves in this subsystem
    localparam logic [1:0] resp_okay = 2'b00;

    // everything a master drives, on all five channels
    typedef struct packed {
        logic [addr_width-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
        logic [addr_width-1:0] awaddr;
        logic                  awvalid;
        logic [data_width-1:0] wdata;
        logic [strb_width-1:0] wstrb;
        logic                  wvalid;
        logic                  bready;
    } bus_req_t;

    // everything a slave drives back
    typedef struct packed {
        logic                  arready;
        logic [data_width-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rvalid;
        logic                  awready;
        logic                  wready;
        logic [1:0]            bresp;
        logic                  bvalid;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    import bus_pkg::*;

    // which master currently owns the memory bus
    typedef enum logic [1:0] {
        grant_idle  = 2'd0,
        grant_fetch = 2'd1,
        grant_lsu   = 2'd2
    } grant_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } lsu_op_e;

    // strb and data only matter for stores
    typedef struct packed {
        lsu_op_e               op;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } lsu_cmd_t;

endpackage

`default_nettype wire

// File: hdl/fetch_port.sv
`default_nettype none

module fetch_port
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_req,
    input  logic [addr_width-1:0] fetch_addr,
    output logic                  fetch_done,
    output logic [data_width-1:0] fetch_instr,
    output logic                  bus_pending,
    output bus_req_t              bus_req,
    input  bus_rsp_t              bus_rsp
);

    logic                  pending_q;
    logic                  arvalid_q;
    logic                  done_q;
    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] instr_q;
    logic                  start;
    logic                  ar_fire;
    logic                  r_fire;

    assign start   = fetch_req & ~pending_q;
    assign ar_fire = arvalid_q & bus_rsp.arready;
    assign r_fire  = pending_q & bus_rsp.rvalid & bus_req.rready;

    // drops in the cycle of the R handshake so the arbiter can move on
    assign bus_pending = pending_q ? ~r_fire : fetch_req;

    always_comb begin
        bus_req         = '0;
        bus_req.araddr  = addr_q;
        bus_req.arvalid = arvalid_q;
        bus_req.rready  = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            arvalid_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= r_fire;
            if (start) begin
                pending_q <= 1'b1;
                arvalid_q <= 1'b1;
            end
            if (ar_fire) begin
                arvalid_q <= 1'b0;
            end
            if (r_fire) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= fetch_addr;
        end
        if (r_fire) begin
            instr_q <= bus_rsp.rdata;
        end
    end

    assign fetch_done  = done_q;
    assign fetch_instr = instr_q;

endmodule

`default_nettype wire

// File: hdl/lsu_port.sv
`default_nettype none

module lsu_port
    import bus_pkg::*;
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lsu_req,
    input  lsu_cmd_t              lsu_cmd,
    output logic                  lsu_done,
    output logic [data_width-1:0] load_data,
    output logic                  bus_pending,
    output bus_req_t              bus_req,
    input  bus_rsp_t              bus_rsp
);

    lsu_cmd_t              cmd_q;
    logic                  pending_q;
    logic                  ar_sent_q;
    logic                  aw_sent_q;
    logic                  w_sent_q;
    logic                  done_q;
    logic [data_width-1:0] load_q;
    logic                  start;
    logic                  is_store;
    logic                  ar_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  final_fire;

    assign start    = lsu_req & ~pending_q;
    assign is_store = (cmd_q.op == op_store);

    // each valid is derived from the sent flags, so it falls on its own transfer
    always_comb begin
        bus_req.araddr  = cmd_q.addr;
        bus_req.arvalid = pending_q & ~is_store & ~ar_sent_q;
        bus_req.rready  = 1'b1;
        bus_req.awaddr  = cmd_q.addr;
        bus_req.awvalid = pending_q & is_store & ~aw_sent_q;
        bus_req.wdata   = cmd_q.data;
        bus_req.wstrb   = cmd_q.strb;
        bus_req.wvalid  = pending_q & is_store & ~w_sent_q;
        bus_req.bready  = 1'b1;
    end

    assign ar_fire = bus_req.arvalid & bus_rsp.arready;
    assign aw_fire = bus_req.awvalid & bus_rsp.awready;
    assign w_fire  = bus_req.wvalid & bus_rsp.wready;

    // a load ends on R, a store on B
    assign final_fire = pending_q & (is_store ? (bus_rsp.bvalid & bus_req.bready)
                                              : (bus_rsp.rvalid & bus_req.rready));

    assign bus_pending = pending_q ? ~final_fire : lsu_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            ar_sent_q <= 1'b0;
            aw_sent_q <= 1'b0;
            w_sent_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= final_fire;
            if (start) begin
                pending_q <= 1'b1;
                ar_sent_q <= 1'b0;
                aw_sent_q <= 1'b0;
                w_sent_q  <= 1'b0;
            end else begin
                if (ar_fire) begin
                    ar_sent_q <= 1'b1;
                end
                if (aw_fire) begin
                    aw_sent_q <= 1'b1;
                end
                if (w_fire) begin
                    w_sent_q <= 1'b1;
                end
                if (final_fire) begin
                    pending_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q <= lsu_cmd;
        end
        if (final_fire && !is_store) begin
            load_q <= bus_rsp.rdata;
        end
    end

    assign lsu_done  = done_q;
    assign load_data = load_q;

endmodule

`default_nettype wire

// File: hdl/bus_arbiter.sv
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_pending,
    input  logic     lsu_pending,
    input  bus_req_t fetch_req,
    input  bus_req_t lsu_req,
    output bus_rsp_t fetch_rsp,
    output bus_rsp_t lsu_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp
);

    grant_e grant_q;
    grant_e grant_d;
    logic   owner_final;
    logic   rearbitrate;

    // mem_req is the owner's request, so this is the owner's last handshake
    assign owner_final = (mem_rsp.rvalid & mem_req.rready)
                       | (mem_rsp.bvalid & mem_req.bready);

    always_comb begin
        case (grant_q)
            grant_fetch: rearbitrate = owner_final;
            grant_lsu:   rearbitrate = owner_final;
            default:     rearbitrate = 1'b1;
        endcase
    end

    // load/store always wins when both want the bus
    always_comb begin
        grant_d = grant_q;
        if (rearbitrate) begin
            if (lsu_pending) begin
                grant_d = grant_lsu;
            end else if (fetch_pending) begin
                grant_d = grant_fetch;
            end else begin
                grant_d = grant_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= grant_idle;
        end else begin
            grant_q <= grant_d;
        end
    end

    // the master without the grant sees every valid and ready low
    always_comb begin
        mem_req   = '0;
        fetch_rsp = '0;
        lsu_rsp   = '0;
        case (grant_q)
            grant_fetch: begin
                mem_req   = fetch_req;
                fetch_rsp = mem_rsp;
            end
            grant_lsu: begin
                mem_req = lsu_req;
                lsu_rsp = mem_rsp;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/sram_slave.sv
`default_nettype none

module sram_slave
    import bus_pkg::*;
#(
    parameter int mem_words    = 256,
    parameter int read_latency = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp
);

    localparam int lane_bits = $clog2(strb_width);
    localparam int idx_w     = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam int cnt_w     = $clog2(read_latency + 1);
    localparam logic [cnt_w-1:0] lat_load = cnt_w'(read_latency - 1);

    logic [data_width-1:0] mem [mem_words];

    logic                  rd_busy_q;
    logic [cnt_w-1:0]      rd_cnt_q;
    logic [data_width-1:0] rdata_q;
    logic                  aw_held_q;
    logic                  w_held_q;
    logic [idx_w-1:0]      wr_idx_q;
    logic [data_width-1:0] wdata_q;
    logic [strb_width-1:0] wstrb_q;
    logic                  wr_busy_q;
    logic [cnt_w-1:0]      wr_cnt_q;
    logic                  ar_fire;
    logic                  r_fire;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;
    logic                  wr_commit;

    function automatic logic [idx_w-1:0] word_index(input logic [addr_width-1:0] addr);
        return idx_w'((addr >> lane_bits) % mem_words);
    endfunction

    function automatic logic [data_width-1:0] merge_bytes(
        input logic [data_width-1:0] old_word,
        input logic [data_width-1:0] new_word,
        input logic [strb_width-1:0] strb
    );
        logic [data_width-1:0] merged;
        merged = old_word;
        for (int i = 0; i < strb_width; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_comb begin
        bus_rsp.arready = ~rd_busy_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = resp_okay;
        bus_rsp.rvalid  = rd_busy_q & (rd_cnt_q == '0);
        bus_rsp.awready = ~aw_held_q & ~wr_busy_q;
        bus_rsp.wready  = ~w_held_q & ~wr_busy_q;
        bus_rsp.bresp   = resp_okay;
        bus_rsp.bvalid  = wr_busy_q & (wr_cnt_q == '0);
    end

    assign ar_fire   = bus_req.arvalid & bus_rsp.arready;
    assign r_fire    = bus_rsp.rvalid & bus_req.rready;
    assign aw_fire   = bus_req.awvalid & bus_rsp.awready;
    assign w_fire    = bus_req.wvalid & bus_rsp.wready;
    assign b_fire    = bus_rsp.bvalid & bus_req.bready;
    assign wr_commit = aw_held_q & w_held_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_busy_q <= 1'b0;
            rd_cnt_q  <= '0;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            wr_busy_q <= 1'b0;
            wr_cnt_q  <= '0;
        end else begin
            if (ar_fire) begin
                rd_busy_q <= 1'b1;
                rd_cnt_q  <= lat_load;
            end else if (r_fire) begin
                rd_busy_q <= 1'b0;
            end else if (rd_busy_q && rd_cnt_q != '0) begin
                rd_cnt_q <= rd_cnt_q - 1'b1;
            end
            if (aw_fire) begin
                aw_held_q <= 1'b1;
            end
            if (w_fire) begin
                w_held_q <= 1'b1;
            end
            // address and data may arrive in either order, the response waits for both
            if (wr_commit) begin
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
                wr_busy_q <= 1'b1;
                wr_cnt_q  <= lat_load;
            end else if (b_fire) begin
                wr_busy_q <= 1'b0;
            end else if (wr_busy_q && wr_cnt_q != '0) begin
                wr_cnt_q <= wr_cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q <= mem[word_index(bus_req.araddr)];
        end
        if (aw_fire) begin
            wr_idx_q <= word_index(bus_req.awaddr);
        end
        if (w_fire) begin
            wdata_q <= bus_req.wdata;
            wstrb_q <= bus_req.wstrb;
        end
        if (wr_commit) begin
            mem[wr_idx_q] <= merge_bytes(mem[wr_idx_q], wdata_q, wstrb_q);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top
    import bus_pkg::*;
    import core_pkg::*;
#(
    parameter int mem_words    = 256,
    parameter int read_latency = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_req,
    input  logic [addr_width-1:0] fetch_addr,
    output logic                  fetch_done,
    output logic [data_width-1:0] fetch_instr,
    input  logic                  lsu_req,
    input  lsu_cmd_t              lsu_cmd,
    output logic                  lsu_done,
    output logic [data_width-1:0] load_data
);

    bus_req_t fetch_bus_req;
    bus_rsp_t fetch_bus_rsp;
    bus_req_t lsu_bus_req;
    bus_rsp_t lsu_bus_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    logic     fetch_pending;
    logic     lsu_pending;

    fetch_port u_fetch_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_instr (fetch_instr),
        .bus_pending (fetch_pending),
        .bus_req     (fetch_bus_req),
        .bus_rsp     (fetch_bus_rsp)
    );

    lsu_port u_lsu_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .lsu_req     (lsu_req),
        .lsu_cmd     (lsu_cmd),
        .lsu_done    (lsu_done),
        .load_data   (load_data),
        .bus_pending (lsu_pending),
        .bus_req     (lsu_bus_req),
        .bus_rsp     (lsu_bus_rsp)
    );

    bus_arbiter u_bus_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_pending (fetch_pending),
        .lsu_pending   (lsu_pending),
        .fetch_req     (fetch_bus_req),
        .lsu_req       (lsu_bus_req),
        .fetch_rsp     (fetch_bus_rsp),
        .lsu_rsp       (lsu_bus_rsp),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp)
    );

    sram_slave #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) u_sram_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (mem_req),
        .bus_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// File: bench/mem_subsys_asserts.sv
`default_nettype none

module mem_subsys_asserts
    import bus_pkg::*;
    import core_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input grant_e   grant,
    input bus_rsp_t fetch_rsp,
    input bus_rsp_t lsu_rsp,
    input bus_req_t mem_req,
    input bus_rsp_t mem_rsp
);

    // a master without the grant sees a quiet response bus
    fetch_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        grant != grant_fetch |-> !(fetch_rsp.arready | fetch_rsp.rvalid | fetch_rsp.awready
                                   | fetch_rsp.wready | fetch_rsp.bvalid))
        else $error("fetch port sees a valid or ready without the grant");

    lsu_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        grant != grant_lsu |-> !(lsu_rsp.arready | lsu_rsp.rvalid | lsu_rsp.awready
                                 | lsu_rsp.wready | lsu_rsp.bvalid))
        else $error("load/store port sees a valid or ready without the grant");

    // a downstream address valid may only fall once its transfer has happened
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req.arvalid) |-> $past(mem_rsp.arready))
        else $error("read address valid dropped before its transfer");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(mem_req.awvalid) |-> $past(mem_rsp.awready))
        else $error("write address valid dropped before its transfer");

    reset_grant: assert property (@(posedge clk) !rst_n |=> grant == grant_idle)
        else $error("grant is not idle after reset");

endmodule

bind bus_arbiter mem_subsys_asserts u_arbiter_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant_q),
    .fetch_rsp (fetch_rsp),
    .lsu_rsp   (lsu_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
);

`default_nettype wire

// File: bench/tb_mem_subsys.sv
`default_nettype none

module tb_mem_subsys
    import bus_pkg::*;
    import core_pkg::*;
();

    localparam int mem_words    = 256;
    localparam int read_latency = 2;
    // about 200 transactions at up to 20 cycles each, rounded up
    localparam int timeout_cycles = 5000;
    localparam logic [addr_width-1:0] window_base = 32'h0000_0100;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  fetch_req;
    logic [addr_width-1:0] fetch_addr;
    logic                  fetch_done;
    logic [data_width-1:0] fetch_instr;
    logic                  lsu_req;
    lsu_cmd_t              lsu_cmd;
    logic                  lsu_done;
    logic [data_width-1:0] load_data;

    // reference copy of the 16-word window, updated in completion order
    logic [data_width-1:0] ref_mem [16];
    logic [31:0]           rng_state = 32'h5f4a;
    int                    fetch_issued = 0;
    int                    fetch_seen = 0;
    int                    lsu_issued = 0;
    int                    lsu_seen = 0;
    int                    cycle_count = 0;
    logic [addr_width-1:0] fetch_cur_addr;
    lsu_cmd_t              lsu_cur_cmd;

    always #10 clk = ~clk;

    mem_subsys_top #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) u_mem_subsys_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_instr (fetch_instr),
        .lsu_req     (lsu_req),
        .lsu_cmd     (lsu_cmd),
        .lsu_done    (lsu_done),
        .load_data   (load_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // strobed byte lanes take the new data, the others keep the old word
    function automatic logic [data_width-1:0] merge_ref(
        input logic [data_width-1:0] old_word,
        input logic [data_width-1:0] new_word,
        input logic [strb_width-1:0] strb
    );
        logic [data_width-1:0] mask;
        for (int i = 0; i < strb_width; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [addr_width-1:0] word_addr(input logic [3:0] idx);
        return window_base + addr_width'({idx, 2'b00});
    endfunction

    function automatic logic [strb_width-1:0] partial_strb(input logic [31:0] r);
        logic [strb_width-1:0] strb;
        strb = r[3:0];
        if (strb == 4'h0 || strb == 4'hf) begin
            strb = 4'b0110;
        end
        return strb;
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    task automatic instr_check(input logic [data_width-1:0] got, input logic [data_width-1:0] exp);
        if (got !== exp) begin
            $display("FAILED time=%0t signal=fetch_instr got=%h expected=%h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic load_check(input logic [data_width-1:0] got, input logic [data_width-1:0] exp);
        if (got !== exp) begin
            $display("FAILED time=%0t signal=load_data got=%h expected=%h", $time, got, exp);
            stop_run();
        end
    endtask

    // every request is a single-cycle pulse, so each new cycle clears both
    task automatic step();
        @(posedge clk);
        #2;
        fetch_req = 1'b0;
        lsu_req   = 1'b0;
    endtask

    task automatic wait_idle();
        while (fetch_issued != fetch_seen || lsu_issued != lsu_seen) begin
            step();
        end
    endtask

    task automatic raise_fetch(input logic [addr_width-1:0] addr);
        fetch_addr     = addr;
        fetch_req      = 1'b1;
        fetch_cur_addr = addr;
        fetch_issued++;
    endtask

    task automatic raise_lsu(input lsu_op_e op, input logic [3:0] idx,
                             input logic [data_width-1:0] data,
                             input logic [strb_width-1:0] strb);
        lsu_cmd.op   = op;
        lsu_cmd.addr = word_addr(idx);
        lsu_cmd.data = data;
        lsu_cmd.strb = strb;
        lsu_req      = 1'b1;
        lsu_cur_cmd  = lsu_cmd;
        lsu_issued++;
    endtask

    // done pulses never coincide because the arbiter serializes whole transactions
    always @(negedge clk) begin
        if (rst_n) begin
            if (lsu_done) begin
                if (lsu_issued == lsu_seen) begin
                    $display("lsu_done pulsed with no load or store outstanding");
                    stop_run();
                end
                if (lsu_cur_cmd.op == op_store) begin
                    ref_mem[lsu_cur_cmd.addr[5:2]] = merge_ref(ref_mem[lsu_cur_cmd.addr[5:2]],
                                                               lsu_cur_cmd.data, lsu_cur_cmd.strb);
                end else begin
                    load_check(load_data, ref_mem[lsu_cur_cmd.addr[5:2]]);
                end
                lsu_seen++;
            end
            if (fetch_done) begin
                if (fetch_issued == fetch_seen) begin
                    $display("fetch_done pulsed with no fetch outstanding");
                    stop_run();
                end
                instr_check(fetch_instr, ref_mem[fetch_cur_addr[5:2]]);
                fetch_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            stop_run();
        end
    end

    initial begin
        logic [31:0]           r;
        logic [3:0]            idx;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [data_width-1:0] expect_new;
        int                    n;

        rst_n      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        lsu_req    = 1'b0;
        lsu_cmd    = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // any done pulse here is caught by the compare process
        repeat (5) step();
        for (int i = 0; i < 16; i++) begin
            raise_lsu(op_store, 4'(i), next_random(), 4'hf);
            wait_idle();
        end

        for (int i = 0; i < 16; i++) begin
            raise_fetch(word_addr(4'(i)));
            wait_idle();
        end

        for (int i = 0; i < 20; i++) begin
            r = next_random();
            idx = r[7:4];
            raise_lsu(op_store, idx, next_random(), partial_strb(r >> 8));
            wait_idle();
            raise_lsu(op_load, idx, '0, '0);
            wait_idle();
        end

        for (int i = 0; i < 6; i++) begin
            r = next_random();
            raise_fetch(word_addr(r[3:0]));
            raise_lsu(r[8] ? op_store : op_load, r[7:4], next_random(), partial_strb(r >> 12));
            wait_idle();
        end

        // load/store wins from idle, so the fetch must see the stored bytes
        for (int i = 0; i < 2; i++) begin
            r = next_random();
            idx = r[3:0];
            data = next_random();
            strb = partial_strb(r >> 4);
            expect_new = merge_ref(ref_mem[idx], data, strb);
            raise_fetch(word_addr(idx));
            raise_lsu(op_store, idx, data, strb);
            wait_idle();
            instr_check(fetch_instr, expect_new);
        end

        n = 0;
        while (n < 120) begin
            r = next_random();
            if (fetch_issued == fetch_seen && r[0]) begin
                raise_fetch(word_addr(r[7:4]));
                n++;
            end
            if (lsu_issued == lsu_seen && r[1]) begin
                strb = r[3] ? 4'hf : partial_strb(r >> 12);
                raise_lsu(r[2] ? op_store : op_load, r[11:8], next_random(), strb);
                n++;
            end
            step();
        end
        wait_idle();
        repeat (3) step();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/bus_pkg.sv
hdl/core_pkg.sv
hdl/fetch_port.sv
hdl/lsu_port.sv
hdl/bus_arbiter.sv
hdl/sram_slave.sv
hdl/mem_subsys_top.sv
bench/mem_subsys_asserts.sv
bench/tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
# the exit status is the simulator's, so a $fatal or a failed assertion fails the script
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys \
    -f tb.f -o sim_tb_mem_subsys \
    && ./obj_dir/sim_tb_mem_subsys \
    || exit 1
